/* logic/encap_params.svh */
// ##########################################################
// Sizes, flow-control limits and register map of the engine
// The table depth and the FIFO depth must be powers of two
// ##########################################################
`ifndef ENCAP_PARAMS_SVH
`define ENCAP_PARAMS_SVH

`define ENCAP_WORD_W        32
`define ENCAP_TBL_DEPTH     16
`define ENCAP_FIFO_DEPTH    16
`define ENCAP_BP_MARGIN     4      // Free slots left when in_bp rises
`define ENCAP_OUT_CREDITS   4

`define ENCAP_REG_SRC_ADDR  8'h00
`define ENCAP_REG_QOS       8'h01
`define ENCAP_TBL_BASE      8'h10  // Table spans base to base + depth - 1

`endif

/* logic/encap_pkg.sv */
// ##########################################################
// Shared types of the encapsulation engine
// ##########################################################
`include "encap_params.svh"

package encap_pkg;

    typedef logic [`ENCAP_WORD_W-1:0] word_t;
    typedef logic [7:0] pio_addr_t;
    typedef logic [$clog2(`ENCAP_TBL_DEPTH)-1:0] tunnel_idx_t;
    typedef logic [15:0] seq_t;
    typedef logic [$clog2(`ENCAP_OUT_CREDITS+1)-1:0] credit_t;

    typedef enum logic [2:0] {
        IDLE, LOOKUP, HDR_TUNNEL, HDR_SRC, HDR_QOS, PAYLOAD
    } ctrl_state_t;

    typedef enum logic [1:0] {
        SEL_TUNNEL, SEL_SRC, SEL_QOS, SEL_PAYLOAD
    } word_sel_t;

endpackage

/* logic/encap_pio.sv */
`timescale 1ns/1ns
// ##########################################################
// Register bus: address on the start cycle, write data on the next
// Ack comes two cycles after start, rdata is valid with rvalid only
// Unmapped addresses read as zero, writes to them are dropped
// QoS register: TTL in [31:24], DSCP/ECN in [23:16]
// ##########################################################
`include "encap_params.svh"

module encap_pio (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   pio_start,
    input  logic                   pio_rw,
    input  encap_pkg::word_t       pio_addr_wdata,
    input  encap_pkg::word_t       tbl_rdata,
    output logic                   pio_ack,
    output logic                   pio_rvalid,
    output encap_pkg::word_t       pio_rdata,
    output logic                   tbl_wr,
    output logic                   tbl_rd,
    output encap_pkg::tunnel_idx_t tbl_addr,
    output encap_pkg::word_t       tbl_wdata,
    output encap_pkg::word_t       src_addr,
    output encap_pkg::word_t       qos
);
    import encap_pkg::*;

    logic      busy;        // Second bus cycle, data or read slot
    logic      rw_q;
    pio_addr_t addr_q;
    logic      sel_src;
    logic      sel_qos;
    logic      sel_tbl;
    logic      rd_tbl_q;    // Read data comes from the table
    word_t     rd_reg_q;

    assign sel_src = addr_q == `ENCAP_REG_SRC_ADDR;
    assign sel_qos = addr_q == `ENCAP_REG_QOS;
    assign sel_tbl = (addr_q >> $bits(tunnel_idx_t)) ==
                     (`ENCAP_TBL_BASE >> $bits(tunnel_idx_t));

    assign tbl_addr  = addr_q[$bits(tunnel_idx_t)-1:0];
    assign tbl_wdata = pio_addr_wdata;
    assign tbl_wr    = busy && !rw_q && sel_tbl;
    assign tbl_rd    = busy && rw_q && sel_tbl;
    assign pio_rdata = rd_tbl_q ? tbl_rdata : rd_reg_q;

    always_ff @(posedge clk) begin
        if (pio_start) begin
            rw_q   <= pio_rw;
            addr_q <= pio_addr_wdata[$bits(pio_addr_t)-1:0];
        end
        if (busy) begin
            rd_tbl_q <= sel_tbl;
            rd_reg_q <= sel_src ? src_addr : (sel_qos ? qos : '0);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy       <= 1'b0;
            pio_ack    <= 1'b0;
            pio_rvalid <= 1'b0;
            src_addr   <= '0;
            qos        <= '0;
        end else begin
            busy       <= pio_start;
            pio_ack    <= busy;
            pio_rvalid <= busy && rw_q;
            if (busy && !rw_q && sel_src) src_addr <= pio_addr_wdata;
            if (busy && !rw_q && sel_qos) qos <= pio_addr_wdata;
        end
    end

endmodule

/* logic/encap_tunnel_table.sv */
`timescale 1ns/1ns
// ##########################################################
// Tunnel destination table, one write port, two read ports
// Contents power up as zero and are not cleared by reset
// A read in the same cycle as a write returns the old entry
// ##########################################################
`include "encap_params.svh"

module encap_tunnel_table (
    input  logic                   clk,
    input  logic                   tbl_wr,
    input  logic                   tbl_rd,
    input  encap_pkg::tunnel_idx_t tbl_addr,
    input  encap_pkg::word_t       tbl_wdata,
    input  logic                   lookup_rd,
    input  encap_pkg::tunnel_idx_t lookup_idx,
    output encap_pkg::word_t       tbl_rdata,
    output encap_pkg::word_t       lookup_data
);
    import encap_pkg::*;

    word_t mem [`ENCAP_TBL_DEPTH];

    initial begin
        for (int i = 0; i < `ENCAP_TBL_DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (tbl_wr) mem[tbl_addr] <= tbl_wdata;
    end

    // Bus read port
    always_ff @(posedge clk) begin
        if (tbl_rd) tbl_rdata <= mem[tbl_addr];
    end

    // Lookup port, holds the entry until the next lookup
    always_ff @(posedge clk) begin
        if (lookup_rd) lookup_data <= mem[lookup_idx];
    end

endmodule

/* logic/encap_payload_fifo.sv */
`timescale 1ns/1ns
// ##########################################################
// Show-ahead input buffer, head is valid whenever empty is low
// in_bp rises at depth minus margin, the source must obey it
// ##########################################################
`include "encap_params.svh"

module encap_payload_fifo (
    input  logic             clk,
    input  logic             reset,
    input  logic             in_valid,
    input  encap_pkg::word_t in_data,
    input  logic             in_sop,
    input  logic             in_eop,
    input  logic             pop,
    output encap_pkg::word_t head_data,
    output logic             head_sop,
    output logic             head_eop,
    output logic             empty,
    output logic             in_bp
);
    import encap_pkg::*;

    localparam int PTR_W = $clog2(`ENCAP_FIFO_DEPTH);

    word_t            data_mem [`ENCAP_FIFO_DEPTH];
    logic             sop_mem  [`ENCAP_FIFO_DEPTH];
    logic             eop_mem  [`ENCAP_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             full;

    assign empty     = count == '0;
    assign full      = count == (PTR_W+1)'(`ENCAP_FIFO_DEPTH);
    assign in_bp     = count >= (PTR_W+1)'(`ENCAP_FIFO_DEPTH - `ENCAP_BP_MARGIN);
    assign head_data = data_mem[rd_ptr];
    assign head_sop  = sop_mem[rd_ptr];
    assign head_eop  = eop_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (in_valid) begin
            data_mem[wr_ptr] <= in_data;
            sop_mem[wr_ptr]  <= in_sop;
            eop_mem[wr_ptr]  <= in_eop;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({in_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Source has to stop on in_bp before the margin runs out
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        in_valid |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        pop |-> !empty);

endmodule

/* logic/encap_frame_builder.sv */
`timescale 1ns/1ns
// ##########################################################
// Output stage, one word appears the cycle after emit
// QoS word is {qos[31:16], sequence}, sequence starts at zero
// out_data holds the last word while out_valid is low
// ##########################################################
`include "encap_params.svh"

module encap_frame_builder (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 emit,
    input  encap_pkg::word_sel_t word_sel,
    input  logic                 pkt_done,
    input  encap_pkg::word_t     lookup_data,
    input  encap_pkg::word_t     src_addr,
    input  encap_pkg::word_t     qos,
    input  encap_pkg::word_t     head_data,
    input  logic                 head_eop,
    output logic                 out_valid,
    output encap_pkg::word_t     out_data,
    output logic                 out_sop,
    output logic                 out_eop
);
    import encap_pkg::*;

    seq_t  seq;
    word_t sel_word;

    always_comb begin
        case (word_sel)
            SEL_TUNNEL: sel_word = lookup_data;
            SEL_SRC:    sel_word = src_addr;
            SEL_QOS:    sel_word = {qos[`ENCAP_WORD_W-1:$bits(seq_t)], seq};
            default:    sel_word = head_data;
        endcase
    end

    always_ff @(posedge clk) begin
        if (emit) out_data <= sel_word;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
            out_sop   <= 1'b0;
            out_eop   <= 1'b0;
            seq       <= '0;
        end else begin
            out_valid <= emit;
            out_sop   <= emit && word_sel == SEL_TUNNEL;
            out_eop   <= emit && word_sel == SEL_PAYLOAD && head_eop;
            if (pkt_done) seq <= seq + 1'b1;    // Next packet number
        end
    end

endmodule

/* logic/encap_ctrl.sv */
`timescale 1ns/1ns
// ##########################################################
// Packet FSM and output credit counter
// One word per cycle while credit lasts, stalls at zero credit
// The receiver must never return more credits than words sent
// ##########################################################
`include "encap_params.svh"

module encap_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 empty,
    input  logic                 head_sop,
    input  logic                 head_eop,
    input  logic                 out_credit,
    output logic                 pop,
    output logic                 lookup_rd,
    output logic                 emit,
    output encap_pkg::word_sel_t word_sel,
    output logic                 pkt_done
);
    import encap_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_nx;
    credit_t     credit;
    logic        has_credit;

    assign has_credit = credit != '0;

    always_comb begin
        state_nx  = state;
        pop       = 1'b0;
        lookup_rd = 1'b0;
        emit      = 1'b0;
        word_sel  = SEL_PAYLOAD;
        pkt_done  = 1'b0;
        case (state)
            IDLE: begin
                if (!empty) state_nx = LOOKUP;
            end
            LOOKUP: begin
                lookup_rd = 1'b1;       // Index from the sop word at the head
                state_nx  = HDR_TUNNEL;
            end
            HDR_TUNNEL: begin
                word_sel = SEL_TUNNEL;
                emit     = has_credit;
                if (has_credit) state_nx = HDR_SRC;
            end
            HDR_SRC: begin
                word_sel = SEL_SRC;
                emit     = has_credit;
                if (has_credit) state_nx = HDR_QOS;
            end
            HDR_QOS: begin
                word_sel = SEL_QOS;
                emit     = has_credit;
                if (has_credit) state_nx = PAYLOAD;
            end
            PAYLOAD: begin
                emit     = has_credit && !empty;    // Payload may still be arriving
                pop      = emit;
                pkt_done = emit && head_eop;
                if (pkt_done) state_nx = IDLE;
            end
            default: state_nx = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= IDLE;
            credit <= credit_t'(`ENCAP_OUT_CREDITS);
        end else begin
            state  <= state_nx;
            credit <= credit + credit_t'(out_credit) - credit_t'(emit);
        end
    end

    // Buffer keeps packets aligned, a new packet starts on sop
    a_sop_at_start: assert property (@(posedge clk) disable iff (reset)
        (state == IDLE && !empty) |-> head_sop);
    a_credit_max: assert property (@(posedge clk) disable iff (reset)
        credit <= credit_t'(`ENCAP_OUT_CREDITS));

endmodule

/* logic/encap_top.sv */
`timescale 1ns/1ns
// ##########################################################
// Tunnel encapsulation engine, single port, single clock
// Each packet leaves as tunnel, source, QoS words then payload
// ##########################################################

module encap_top (
    input  logic             clk,
    input  logic             reset,
    input  logic             pio_start,
    input  logic             pio_rw,
    input  encap_pkg::word_t pio_addr_wdata,
    input  logic             in_valid,
    input  encap_pkg::word_t in_data,
    input  logic             in_sop,
    input  logic             in_eop,
    input  logic             out_credit,
    output logic             pio_ack,
    output logic             pio_rvalid,
    output encap_pkg::word_t pio_rdata,
    output logic             in_bp,
    output logic             out_valid,
    output encap_pkg::word_t out_data,
    output logic             out_sop,
    output logic             out_eop
);
    import encap_pkg::*;

    logic        tbl_wr;
    logic        tbl_rd;
    tunnel_idx_t tbl_addr;
    word_t       tbl_wdata;
    word_t       tbl_rdata;
    word_t       src_addr;
    word_t       qos;
    word_t       lookup_data;
    word_t       head_data;
    logic        head_sop;
    logic        head_eop;
    logic        empty;
    logic        pop;
    logic        lookup_rd;
    logic        emit;
    word_sel_t   word_sel;
    logic        pkt_done;

    encap_pio u_pio (
        .clk(clk),
        .reset(reset),
        .pio_start(pio_start),
        .pio_rw(pio_rw),
        .pio_addr_wdata(pio_addr_wdata),
        .tbl_rdata(tbl_rdata),
        .pio_ack(pio_ack),
        .pio_rvalid(pio_rvalid),
        .pio_rdata(pio_rdata),
        .tbl_wr(tbl_wr),
        .tbl_rd(tbl_rd),
        .tbl_addr(tbl_addr),
        .tbl_wdata(tbl_wdata),
        .src_addr(src_addr),
        .qos(qos)
    );

    encap_tunnel_table u_tunnel_table (
        .clk(clk),
        .tbl_wr(tbl_wr),
        .tbl_rd(tbl_rd),
        .tbl_addr(tbl_addr),
        .tbl_wdata(tbl_wdata),
        .lookup_rd(lookup_rd),
        .lookup_idx(head_data[$bits(tunnel_idx_t)-1:0]),    // Direct index
        .tbl_rdata(tbl_rdata),
        .lookup_data(lookup_data)
    );

    encap_payload_fifo u_payload_fifo (
        .clk(clk),
        .reset(reset),
        .in_valid(in_valid),
        .in_data(in_data),
        .in_sop(in_sop),
        .in_eop(in_eop),
        .pop(pop),
        .head_data(head_data),
        .head_sop(head_sop),
        .head_eop(head_eop),
        .empty(empty),
        .in_bp(in_bp)
    );

    encap_frame_builder u_frame_builder (
        .clk(clk),
        .reset(reset),
        .emit(emit),
        .word_sel(word_sel),
        .pkt_done(pkt_done),
        .lookup_data(lookup_data),
        .src_addr(src_addr),
        .qos(qos),
        .head_data(head_data),
        .head_eop(head_eop),
        .out_valid(out_valid),
        .out_data(out_data),
        .out_sop(out_sop),
        .out_eop(out_eop)
    );

    encap_ctrl u_ctrl (
        .clk(clk),
        .reset(reset),
        .empty(empty),
        .head_sop(head_sop),
        .head_eop(head_eop),
        .out_credit(out_credit),
        .pop(pop),
        .lookup_rd(lookup_rd),
        .emit(emit),
        .word_sel(word_sel),
        .pkt_done(pkt_done)
    );

endmodule

/* bench/encap_tb.sv */
`timescale 1ns/1ns
// ##########################################################
// Directed testbench for the encapsulation engine
// Inputs change 1 ns after the rising edge, outputs are read
// on the falling edge, credits return after 0 to 3 cycles
// ##########################################################
`include "encap_params.svh"

module encap_tb;
    import encap_pkg::*;

    localparam int MAX_CYCLES = 5000;   // Over ten times the length of all tests

    logic  clk;
    logic  reset;
    logic  pio_start;
    logic  pio_rw;
    word_t pio_addr_wdata;
    logic  in_valid;
    word_t in_data;
    logic  in_sop;
    logic  in_eop;
    logic  out_credit;
    logic  pio_ack;
    logic  pio_rvalid;
    word_t pio_rdata;
    logic  in_bp;
    logic  out_valid;
    word_t out_data;
    logic  out_sop;
    logic  out_eop;

    word_t       lfsr = 32'h181fc7bc;
    word_t       tbl_model [`ENCAP_TBL_DEPTH];
    word_t       src_model;
    word_t       qos_model;
    logic [15:0] seq_model;
    logic [33:0] exp_q [$];     // {sop, eop, data}
    int          credit_due [$];
    int          cycle;
    int          outstanding;   // Words held by the receiver
    int          errors;
    int          tests_failed;
    logic        hold_credit;
    logic        bp_seen;

    encap_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        cycle = 0;
        while (cycle < MAX_CYCLES) begin
            @(posedge clk);
            cycle++;
        end
        $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // Galois LFSR stepped once per bit taken
    function automatic word_t rand_bits(input int n);
        word_t val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            val  = {val[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return val;
    endfunction

    task automatic check_value(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            errors++;
            $display("error: %s got %h expected %h", name, got, expected);
        end
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("failure: %s", what);
    endtask

    task automatic finish_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - start_errors);
        end
    endtask

    // Receiver checks every word and schedules its credit
    initial begin
        logic [33:0] expected;
        outstanding = 0;
        forever begin
            @(negedge clk);
            if (out_valid) begin
                outstanding++;
                credit_due.push_back(cycle + int'(rand_bits(2)));
                if (outstanding > `ENCAP_OUT_CREDITS)
                    note_failure("receiver holds more words than credits given");
                if (exp_q.size() == 0) begin
                    note_failure("output word while no packet was expected");
                end else begin
                    expected = exp_q.pop_front();
                    check_value("out_data", out_data, expected[31:0]);
                    check_value("out_sop", 32'(out_sop), 32'(expected[33]));
                    check_value("out_eop", 32'(out_eop), 32'(expected[32]));
                end
            end
        end
    end

    // One credit per cycle at most, once its delay has passed
    initial begin
        out_credit = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            out_credit = 1'b0;
            if (!hold_credit && credit_due.size() != 0 && credit_due[0] <= cycle) begin
                void'(credit_due.pop_front());
                outstanding--;
                out_credit = 1'b1;
            end
        end
    end

    task automatic pio_access(input logic rw, input logic [7:0] addr, input word_t wdata,
                              output word_t rdata);
        int wait_cycles;
        pio_start      = 1'b1;
        pio_rw         = rw;
        pio_addr_wdata = {24'h0, addr};
        @(posedge clk);
        #1;
        pio_start      = 1'b0;
        pio_addr_wdata = wdata;     // Data slot is ignored on reads
        wait_cycles    = 0;
        while (!pio_ack && wait_cycles < 4) begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end
        if (!pio_ack) note_failure("register bus gave no acknowledge");
        if (rw) check_value("pio_rvalid", 32'(pio_rvalid), 32'h1);
        rdata = pio_rdata;
    endtask

    task automatic pio_write(input logic [7:0] addr, input word_t data);
        word_t unused;
        pio_access(1'b0, addr, data, unused);
    endtask

    task automatic read_expect(input logic [7:0] addr, input word_t expected);
        word_t got;
        pio_access(1'b1, addr, 32'h0, got);
        check_value("pio_rdata", got, expected);
    endtask

    // Queues the expected frame, then feeds the payload while in_bp allows
    task automatic send_packet(input int len, input logic [3:0] idx);
        word_t w;
        exp_q.push_back({2'b10, tbl_model[idx]});
        exp_q.push_back({2'b00, src_model});
        exp_q.push_back({2'b00, qos_model[31:16], seq_model});
        seq_model++;
        for (int i = 0; i < len; i++) begin
            w = rand_bits(32);
            if (i == 0) w[3:0] = idx;
            exp_q.push_back({1'b0, (i == len - 1), w});
            while (in_bp) begin
                bp_seen  = 1'b1;
                in_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            in_valid = 1'b1;
            in_data  = w;
            in_sop   = (i == 0);
            in_eop   = (i == len - 1);
            @(posedge clk);
            #1;
        end
        in_valid = 1'b0;
        in_sop   = 1'b0;
        in_eop   = 1'b0;
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0 || outstanding != 0) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic test_reset_values();
        int start_errors;
        start_errors = errors;
        check_value("out_valid", 32'(out_valid), 32'h0);
        check_value("in_bp", 32'(in_bp), 32'h0);
        check_value("pio_ack", 32'(pio_ack), 32'h0);
        check_value("pio_rvalid", 32'(pio_rvalid), 32'h0);
        read_expect(`ENCAP_REG_SRC_ADDR, 32'h0);
        read_expect(`ENCAP_REG_QOS, 32'h0);
        for (int i = 0; i < `ENCAP_TBL_DEPTH; i++) read_expect(`ENCAP_TBL_BASE + 8'(i), 32'h0);
        finish_test("reset values", start_errors);
    endtask

    task automatic test_register_access();
        int start_errors;
        start_errors = errors;
        src_model = rand_bits(32);
        qos_model = rand_bits(32);
        pio_write(`ENCAP_REG_SRC_ADDR, src_model);
        pio_write(`ENCAP_REG_QOS, qos_model);
        for (int i = 0; i < `ENCAP_TBL_DEPTH; i++) begin
            tbl_model[i] = rand_bits(32);
            pio_write(`ENCAP_TBL_BASE + 8'(i), tbl_model[i]);
        end
        pio_write(8'h05, 32'hdeadbeef);     // Write to an unmapped address is dropped
        read_expect(`ENCAP_REG_SRC_ADDR, src_model);
        read_expect(`ENCAP_REG_QOS, qos_model);
        for (int i = 0; i < `ENCAP_TBL_DEPTH; i++) begin
            read_expect(`ENCAP_TBL_BASE + 8'(i), tbl_model[i]);
        end
        read_expect(8'h05, 32'h0);
        read_expect(8'h20, 32'h0);
        finish_test("register access", start_errors);
    endtask

    task automatic test_single_packets();
        int start_errors;
        start_errors = errors;
        send_packet(5, 4'h3);
        wait_drained();
        send_packet(1, 4'hc);
        wait_drained();
        finish_test("single packets", start_errors);
    endtask

    task automatic test_back_to_back();
        int start_errors;
        start_errors = errors;
        for (int p = 0; p < 8; p++) send_packet(1 + int'(rand_bits(3)), 4'(rand_bits(4)));
        wait_drained();
        finish_test("back to back packets", start_errors);
    endtask

    task automatic test_back_pressure();
        int start_errors;
        start_errors = errors;
        hold_credit  = 1'b1;
        bp_seen      = 1'b0;
        fork
            send_packet(20, 4'h7);
            begin
                while (!in_bp) begin
                    @(posedge clk);
                    #1;
                end
                repeat (8) begin    // Source must sit still meanwhile
                    @(posedge clk);
                    #1;
                end
                hold_credit = 1'b0;
            end
        join
        wait_drained();
        if (!bp_seen) note_failure("in_bp never paused the source");
        check_value("in_bp", 32'(in_bp), 32'h0);
        finish_test("back pressure", start_errors);
    endtask

    initial begin
        reset          = 1'b1;
        pio_start      = 1'b0;
        pio_rw         = 1'b0;
        pio_addr_wdata = '0;
        in_valid       = 1'b0;
        in_data        = '0;
        in_sop         = 1'b0;
        in_eop         = 1'b0;
        hold_credit    = 1'b0;
        bp_seen        = 1'b0;
        errors         = 0;
        tests_failed   = 0;
        seq_model      = '0;
        src_model      = '0;
        qos_model      = '0;
        for (int i = 0; i < `ENCAP_TBL_DEPTH; i++) tbl_model[i] = '0;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_values();
        test_register_access();
        test_single_packets();
        test_back_to_back();
        test_back_pressure();
        $display("tests run 5, tests failed %0d, check errors %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+logic
logic/encap_pkg.sv
logic/encap_pio.sv
logic/encap_tunnel_table.sv
logic/encap_payload_fifo.sv
logic/encap_frame_builder.sv
logic/encap_ctrl.sv
logic/encap_top.sv
bench/encap_tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --timing --assert
TOP       = encap_tb
FILELIST  = sources.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
